// File: hdl/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// widths shared by the processor port and the bus
`define WB_ADDR_BITS 32
`define WB_DATA_BITS 32

// posted writes held before the processor has to wait
`define WB_QUEUE_DEPTH 16

`endif

// File: hdl/wb_cpu_pkg.sv
`default_nettype none

`include "wb_cfg.svh"

package wb_cpu_pkg;

	typedef logic [`WB_ADDR_BITS-1:0] cpu_addr_t;
	typedef logic [`WB_DATA_BITS-1:0] cpu_data_t;

	// one posted write, address in the upper half
	typedef struct packed {
		cpu_addr_t address;
		cpu_data_t data;
	} write_entry_t;

endpackage

`default_nettype wire

// File: hdl/wb_bus_pkg.sv
`default_nettype none

`include "wb_cfg.svh"

package wb_bus_pkg;

	typedef logic [`WB_ADDR_BITS-1:0] bus_addr_t;
	typedef logic [`WB_DATA_BITS-1:0] bus_data_t;

	// rw line on the bus, high for a write
	typedef enum logic {
		bus_read  = 1'b0,
		bus_write = 1'b1
	} bus_op_e;

endpackage

`default_nettype wire

// File: hdl/wb_write_queue.sv
`default_nettype none

`include "wb_cfg.svh"

module wb_write_queue #(
	parameter int DEPTH = `WB_QUEUE_DEPTH
) (
	input  wire logic                     i_clock,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_push,
	input  wire wb_cpu_pkg::write_entry_t i_push_entry,
	input  wire logic                     i_pop,
	output wb_cpu_pkg::write_entry_t      o_pop_entry,
	output logic                          o_empty,
	output logic                          o_full
);
	import wb_cpu_pkg::*;

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	write_entry_t        mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;

	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_comb begin
		count_next = count;
		case ({i_push, i_pop})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			o_empty <= 1'b1;
			o_full  <= 1'b0;
		end else begin
			if (i_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (i_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count   <= count_next;
			o_empty <= (count_next == '0);
			o_full  <= (count_next == CNT_BITS'(DEPTH));
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_push)
			mem[wr_ptr] <= i_push_entry;
	end

	assign o_pop_entry = mem[rd_ptr]; // head of queue

	a_no_push_full: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_push |-> !o_full)
		else $error("write queue pushed while full");

	a_no_pop_empty: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_pop |-> !o_empty)
		else $error("write queue popped while empty");

endmodule

`default_nettype wire

// File: hdl/wb_cpu_port.sv
`default_nettype none

module wb_cpu_port (
	input  wire logic                     i_clock,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_cpu_request,
	input  wire logic                     i_cpu_rw,
	input  wire wb_cpu_pkg::cpu_addr_t    i_cpu_address,
	input  wire wb_cpu_pkg::cpu_data_t    i_cpu_wdata,
	output logic                          o_cpu_ready,
	output wb_cpu_pkg::cpu_data_t         o_cpu_rdata,
	input  wire logic                     i_queue_full,
	input  wire logic                     i_queue_empty,
	output logic                          o_push,
	output wb_cpu_pkg::write_entry_t      o_push_entry,
	input  wire logic                     i_master_idle,
	output logic                          o_rd_issue,
	output wb_cpu_pkg::cpu_addr_t         o_rd_address,
	input  wire logic                     i_rd_done,
	input  wire wb_cpu_pkg::cpu_data_t    i_rd_data
);
	import wb_cpu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_ack,
		st_read_wait,
		st_read_pending
	} state_e;

	state_e state;
	logic   wr_accept;
	logic   rd_go;

	assign wr_accept = (state == st_idle) && i_cpu_request && i_cpu_rw && !i_queue_full;
	assign rd_go     = (state == st_read_wait) && i_queue_empty && i_master_idle;

	// write goes straight into the queue, acked next cycle
	assign o_push       = wr_accept;
	assign o_push_entry = write_entry_t'{address: i_cpu_address, data: i_cpu_wdata};

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state       <= st_idle;
			o_cpu_ready <= 1'b0;
			o_rd_issue  <= 1'b0;
		end else begin
			o_cpu_ready <= 1'b0;
			o_rd_issue  <= 1'b0;
			case (state)
				st_idle: begin
					if (wr_accept) begin
						o_cpu_ready <= 1'b1;
						state       <= st_ack;
					end else if (i_cpu_request && !i_cpu_rw) begin
						state <= st_read_wait;
					end
				end
				st_ack: state <= st_idle; // request drops after ready
				st_read_wait: begin
					if (rd_go) begin
						o_rd_issue <= 1'b1;
						state      <= st_read_pending;
					end
				end
				st_read_pending: begin
					if (i_rd_done) begin
						o_cpu_ready <= 1'b1;
						state       <= st_ack;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (rd_go)
			o_rd_address <= i_cpu_address;
		if (state == st_read_pending && i_rd_done)
			o_cpu_rdata <= i_rd_data;
	end

	// no push can slip in between the empty check and the issue
	a_issue_empty: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_rd_issue |-> i_queue_empty)
		else $error("read issued with writes still queued");

endmodule

`default_nettype wire

// File: hdl/wb_bus_master.sv
`default_nettype none

module wb_bus_master (
	input  wire logic                     i_clock,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_queue_empty,
	output logic                          o_pop,
	input  wire wb_cpu_pkg::write_entry_t i_pop_entry,
	input  wire logic                     i_rd_issue,
	input  wire wb_cpu_pkg::cpu_addr_t    i_rd_address,
	output logic                          o_rd_done,
	output wb_cpu_pkg::cpu_data_t         o_rd_data,
	output logic                          o_idle,
	output logic                          o_bus_request,
	output wb_bus_pkg::bus_op_e           o_bus_rw,
	output wb_bus_pkg::bus_addr_t         o_bus_address,
	output wb_bus_pkg::bus_data_t         o_bus_wdata,
	input  wire logic                     i_bus_ready,
	input  wire wb_bus_pkg::bus_data_t    i_bus_rdata
);
	import wb_bus_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_write_busy,
		st_read_busy
	} state_e;

	state_e state;
	logic   rd_start;

	assign o_idle   = (state == st_idle);
	assign o_pop    = o_idle && !i_queue_empty; // queued writes go first
	assign rd_start = o_idle && i_queue_empty && i_rd_issue;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state         <= st_idle;
			o_bus_request <= 1'b0;
			o_bus_rw      <= bus_read;
			o_rd_done     <= 1'b0;
		end else begin
			o_rd_done <= 1'b0;
			case (state)
				st_idle: begin
					if (o_pop) begin
						o_bus_request <= 1'b1;
						o_bus_rw      <= bus_write;
						state         <= st_write_busy;
					end else if (rd_start) begin
						o_bus_request <= 1'b1;
						o_bus_rw      <= bus_read;
						state         <= st_read_busy;
					end
				end
				st_write_busy: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state         <= st_idle;
					end
				end
				st_read_busy: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_rd_done     <= 1'b1;
						state         <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (o_pop) begin
			o_bus_address <= i_pop_entry.address;
			o_bus_wdata   <= i_pop_entry.data;
		end else if (rd_start) begin
			o_bus_address <= i_rd_address;
		end
		if (state == st_read_busy && i_bus_ready)
			o_rd_data <= i_bus_rdata;
	end

	// the slave may take its time, the request must not move
	a_hold_request: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_request && !i_bus_ready |=>
			o_bus_request && $stable(o_bus_address) && $stable(o_bus_rw))
		else $error("bus request changed before ready");

endmodule

`default_nettype wire

// File: hdl/write_buffer.sv
`default_nettype none

`include "wb_cfg.svh"

module write_buffer (
	input  wire logic                  i_clock,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_cpu_request,
	input  wire logic                  i_cpu_rw,
	input  wire wb_cpu_pkg::cpu_addr_t i_cpu_address,
	input  wire wb_cpu_pkg::cpu_data_t i_cpu_wdata,
	output logic                       o_cpu_ready,
	output wb_cpu_pkg::cpu_data_t      o_cpu_rdata,
	output logic                       o_bus_request,
	output wb_bus_pkg::bus_op_e        o_bus_rw,
	output wb_bus_pkg::bus_addr_t      o_bus_address,
	output wb_bus_pkg::bus_data_t      o_bus_wdata,
	input  wire logic                  i_bus_ready,
	input  wire wb_bus_pkg::bus_data_t i_bus_rdata
);
	import wb_cpu_pkg::*;

	logic         queue_full;
	logic         queue_empty;
	logic         push;
	write_entry_t push_entry;
	logic         pop;
	write_entry_t pop_entry;
	logic         master_idle;
	logic         rd_issue;
	cpu_addr_t    rd_address;
	logic         rd_done;
	cpu_data_t    rd_data;

	wb_cpu_port u_cpu_port (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_cpu_request (i_cpu_request),
		.i_cpu_rw      (i_cpu_rw),
		.i_cpu_address (i_cpu_address),
		.i_cpu_wdata   (i_cpu_wdata),
		.o_cpu_ready   (o_cpu_ready),
		.o_cpu_rdata   (o_cpu_rdata),
		.i_queue_full  (queue_full),
		.i_queue_empty (queue_empty),
		.o_push        (push),
		.o_push_entry  (push_entry),
		.i_master_idle (master_idle),
		.o_rd_issue    (rd_issue),
		.o_rd_address  (rd_address),
		.i_rd_done     (rd_done),
		.i_rd_data     (rd_data)
	);

	wb_write_queue #(
		.DEPTH (`WB_QUEUE_DEPTH)
	) u_write_queue (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_push       (push),
		.i_push_entry (push_entry),
		.i_pop        (pop),
		.o_pop_entry  (pop_entry),
		.o_empty      (queue_empty),
		.o_full       (queue_full)
	);

	wb_bus_master u_bus_master (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_queue_empty (queue_empty),
		.o_pop         (pop),
		.i_pop_entry   (pop_entry),
		.i_rd_issue    (rd_issue),
		.i_rd_address  (rd_address),
		.o_rd_done     (rd_done),
		.o_rd_data     (rd_data),
		.o_idle        (master_idle),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

endmodule

`default_nettype wire

// File: testbench/tb_bus_memory.sv
`default_nettype none

`include "wb_cfg.svh"

module tb_bus_memory (
	input  wire logic                  i_clock,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_stall,
	input  wire logic                  i_bus_request,
	input  wire wb_bus_pkg::bus_op_e   i_bus_rw,
	input  wire wb_bus_pkg::bus_addr_t i_bus_address,
	input  wire wb_bus_pkg::bus_data_t i_bus_wdata,
	output logic                       o_bus_ready,
	output wb_bus_pkg::bus_data_t      o_bus_rdata,
	output logic [31:0]                o_write_count
);
	import wb_bus_pkg::*;

	localparam int MAX_LATENCY = 12;

	bus_data_t mem [bus_addr_t];
	logic      busy;
	int        wait_left;

	// untouched locations read back a pattern of their address
	function automatic bus_data_t fill_word(input bus_addr_t addr);
		return addr ^ 32'hA5A5_5A5A;
	endfunction

	function automatic bus_data_t read_word(input bus_addr_t addr);
		if (mem.exists(addr))
			return mem[addr];
		return fill_word(addr);
	endfunction

	always @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_bus_ready   <= 1'b0;
			o_bus_rdata   <= '0;
			o_write_count <= '0;
			busy          <= 1'b0;
			wait_left     <= 0;
		end else if (o_bus_ready) begin
			o_bus_ready <= 1'b0; // master takes the transfer here
			busy        <= 1'b0;
			if (i_bus_rw == bus_write) begin
				mem[i_bus_address] = i_bus_wdata;
				o_write_count <= o_write_count + 1;
			end
		end else if (i_bus_request && !i_stall) begin
			if (!busy) begin
				busy      <= 1'b1;
				wait_left <= $urandom_range(0, MAX_LATENCY);
			end else if (wait_left != 0) begin
				wait_left <= wait_left - 1;
			end else begin
				o_bus_ready <= 1'b1;
				o_bus_rdata <= read_word(i_bus_address);
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_write_buffer.sv
`default_nettype none

`include "wb_cfg.svh"

module tb_write_buffer;
	import wb_cpu_pkg::*;
	import wb_bus_pkg::*;

	localparam int WAIT_LIMIT   = 2000; // cycles per wait loop
	localparam int NUM_OPS      = 400;
	localparam int STALL_WRITES = `WB_QUEUE_DEPTH + 8;
	localparam int STALL_CYCLES = 300;

	logic         clock;
	logic         rst_n;
	logic         cpu_request;
	logic         cpu_rw;
	cpu_addr_t    cpu_address;
	cpu_data_t    cpu_wdata;
	logic         cpu_ready;
	cpu_data_t    cpu_rdata;
	logic         bus_request;
	bus_op_e      bus_rw;
	bus_addr_t    bus_address;
	bus_data_t    bus_wdata;
	logic         bus_ready;
	bus_data_t    bus_rdata;
	logic         bus_stall;
	logic [31:0]  bus_write_count;

	cpu_data_t    model_mem [cpu_addr_t];
	write_entry_t expected_writes [$];
	int unsigned  acked_writes;

	write_buffer u_dut (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_cpu_request (cpu_request),
		.i_cpu_rw      (cpu_rw),
		.i_cpu_address (cpu_address),
		.i_cpu_wdata   (cpu_wdata),
		.o_cpu_ready   (cpu_ready),
		.o_cpu_rdata   (cpu_rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	tb_bus_memory u_bus_memory (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_stall       (bus_stall),
		.i_bus_request (bus_request),
		.i_bus_rw      (bus_rw),
		.i_bus_address (bus_address),
		.i_bus_wdata   (bus_wdata),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata),
		.o_write_count (bus_write_count)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
	endtask

	task automatic check_bus_write(input bus_addr_t got_addr, input bus_data_t got_data,
			input bus_addr_t exp_addr, input bus_data_t exp_data);
		if (got_addr !== exp_addr)
			report_failure($sformatf("mismatch o_bus_address: got %h expected %h",
				got_addr, exp_addr));
		if (got_data !== exp_data)
			report_failure($sformatf("mismatch o_bus_wdata: got %h expected %h",
				got_data, exp_data));
	endtask

	task automatic check_read(input cpu_addr_t addr, input cpu_data_t got, input cpu_data_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch o_cpu_rdata at %h: got %h expected %h",
				addr, got, exp));
	endtask

	// memory never written holds its address pattern
	function automatic cpu_data_t model_read(input cpu_addr_t addr);
		if (model_mem.exists(addr))
			return model_mem[addr];
		return addr ^ 32'hA5A5_5A5A;
	endfunction

	function automatic cpu_addr_t random_address();
		return cpu_addr_t'(32'h0000_1000 + ($urandom_range(0, 7) << 2));
	endfunction

	task automatic wait_ready(input string what);
		int cycles;
		cycles = 0;
		while (!cpu_ready && cycles < WAIT_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		if (!cpu_ready)
			report_failure({"timeout waiting for o_cpu_ready on a ", what});
	endtask

	task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data);
		int           start_cycle;
		logic         queue_room;
		write_entry_t entry;
		@(posedge clock);
		cpu_request <= 1'b1;
		cpu_rw      <= 1'b1;
		cpu_address <= addr;
		cpu_wdata   <= data;
		@(posedge clock);
		// fewer writes outstanding than the depth leaves room in the queue
		queue_room  = (acked_writes - bus_write_count) < `WB_QUEUE_DEPTH;
		start_cycle = $time / 8;
		wait_ready("write");
		if (queue_room && ($time / 8) - start_cycle != 1)
			report_failure("write not acknowledged one cycle after its request");
		cpu_request   <= 1'b0;
		entry.address = addr;
		entry.data    = data;
		expected_writes.push_back(entry);
		model_mem[addr] = data;
		acked_writes++;
	endtask

	task automatic cpu_read(input cpu_addr_t addr);
		cpu_data_t expected;
		@(posedge clock);
		expected = model_read(addr); // includes writes still queued
		cpu_request <= 1'b1;
		cpu_rw      <= 1'b0;
		cpu_address <= addr;
		@(posedge clock);
		wait_ready("read");
		check_read(addr, cpu_rdata, expected);
		cpu_request <= 1'b0;
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (bus_write_count != acked_writes && cycles < WAIT_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		if (bus_write_count != acked_writes)
			report_failure("timeout waiting for the write queue to drain");
	endtask

	// bus side scoreboard
	always @(posedge clock) begin
		write_entry_t head;
		if (rst_n && bus_request && bus_ready && bus_rw == bus_write) begin
			if (expected_writes.size() == 0)
				report_failure("bus write seen with no acknowledged write pending");
			head = expected_writes.pop_front();
			check_bus_write(bus_address, bus_wdata, head.address, head.data);
		end
		if (acked_writes > bus_write_count + `WB_QUEUE_DEPTH + 1)
			report_failure("more writes acknowledged than the queue can hold");
	end

	initial begin
		void'($urandom(82));
		rst_n        = 1'b0;
		cpu_request  = 1'b0;
		cpu_rw       = 1'b0;
		cpu_address  = '0;
		cpu_wdata    = '0;
		bus_stall    = 1'b0;
		acked_writes = 0;
		repeat (16) @(posedge clock);
		rst_n <= 1'b1;

		repeat (8) begin
			@(posedge clock);
			check_flag("o_cpu_ready", cpu_ready, 1'b0);
			check_flag("o_bus_request", bus_request, 1'b0);
		end

		for (int n = 0; n < NUM_OPS; n++) begin
			repeat ($urandom_range(0, 2)) @(posedge clock);
			if ($urandom_range(0, 99) < 60)
				cpu_write(random_address(), $urandom());
			else
				cpu_read(random_address());
		end

		// hold the bus and push more writes than the queue takes
		wait_drained();
		@(posedge clock);
		bus_stall <= 1'b1;
		fork
			begin
				for (int n = 0; n < STALL_WRITES; n++)
					cpu_write(random_address(), $urandom());
			end
			begin
				repeat (STALL_CYCLES) @(posedge clock);
				if (acked_writes - bus_write_count != `WB_QUEUE_DEPTH + 1)
					report_failure($sformatf("mismatch held writes: got %h expected %h",
						acked_writes - bus_write_count, `WB_QUEUE_DEPTH + 1));
				bus_stall <= 1'b0;
			end
		join
		wait_drained();

		for (int a = 0; a < 8; a++)
			cpu_read(cpu_addr_t'(32'h0000_1000 + (a << 2)));

		if (expected_writes.size() != 0)
			report_failure("bus writes missing at the end of the run");
		else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/wb_cpu_pkg.sv
hdl/wb_bus_pkg.sv
hdl/wb_write_queue.sv
hdl/wb_cpu_port.sv
hdl/wb_bus_master.sv
hdl/write_buffer.sv
testbench/tb_bus_memory.sv
testbench/tb_write_buffer.sv

// File: Bender.yml
package:
  name: write_buffer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_cpu_pkg.sv
      - hdl/wb_bus_pkg.sv
      - hdl/wb_write_queue.sv
      - hdl/wb_cpu_port.sv
      - hdl/wb_bus_master.sv
      - hdl/write_buffer.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_bus_memory.sv
      - testbench/tb_write_buffer.sv
